//--- source/cpuPkg.sv
package cpuPkg;

	//////////////////////////////
	// widths and counts
	//////////////////////////////
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int linkReg = 31;
	localparam int dataWords = 64;

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	//////////////////////////////
	// instruction encodings
	//////////////////////////////
	// jr uses 000111, not the standard R-type form
	typedef enum logic [5:0] {
		rType = 6'b000000,
		j     = 6'b000010,
		jal   = 6'b000011,
		beq   = 6'b000100,
		jr    = 6'b000111,
		addi  = 6'b001000,
		lw    = 6'b100011,
		sw    = 6'b101011
	} opcode_t;

	typedef enum logic [5:0] {
		fnAdd = 6'b100000,
		fnSub = 6'b100010,
		fnAnd = 6'b100100,
		fnOr  = 6'b100101,
		fnSlt = 6'b101010
	} funct_t;

	typedef enum logic [2:0] {aluAnd, aluOr, aluAdd, aluSub, aluSlt} aluOp_t;
	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSel_t;
	typedef enum logic [1:0] {destRt, destRd, destLink} destSel_t;

	//////////////////////////////
	// stage payloads
	//////////////////////////////
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic aluSrc;
		wbSel_t wbSel;
		destSel_t destSel;
	} ctrl_t;

	typedef struct packed {
		word_t pcPlus4;
		word_t instr;
	} fetchWord_t;

	typedef struct packed {
		logic valid;
		word_t target;
	} redirect_t;

	typedef struct packed {
		ctrl_t ctrl;
		aluOp_t aluOp;
		word_t rsVal;
		word_t rtVal;
		word_t imm;
		word_t pcPlus4;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t dest;
	} decodeOut_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t result;
		word_t storeData;
		word_t pcPlus4;
		regAddr_t dest;
	} execOut_t;

	// one architectural register write
	typedef struct packed {
		logic valid;
		regAddr_t dest;
		word_t data;
	} commit_t;

endpackage

//--- source/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic reset,
	input cpuPkg::regAddr_t rs,
	input cpuPkg::regAddr_t rt,
	input cpuPkg::commit_t commit,
	output cpuPkg::word_t rsVal,
	output cpuPkg::word_t rtVal
);
	import cpuPkg::*;

	word_t regs [32];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (commit.valid) begin
			regs[commit.dest] <= commit.data;
		end
	end

	// write-through so decode sees a same-cycle commit
	always_comb begin
		if (rs == '0) rsVal = '0;
		else if (commit.valid && commit.dest == rs) rsVal = commit.data;
		else rsVal = regs[rs];

		if (rt == '0) rtVal = '0;
		else if (commit.valid && commit.dest == rt) rtVal = commit.data;
		else rtVal = regs[rt];
	end

endmodule

//--- source/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
	input logic clk,
	input logic reset,
	input logic stall,
	input cpuPkg::redirect_t redirect,
	input cpuPkg::word_t instr,
	output cpuPkg::word_t instrAddr,
	output cpuPkg::fetchWord_t fetched
);
	import cpuPkg::*;

	word_t pc;
	word_t pcPlus4;

	assign pcPlus4 = pc + 32'd4;
	assign instrAddr = pc;

	// redirect wins; a stall freezes the PC
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= '0;
		end else if (redirect.valid) begin
			pc <= redirect.target;
		end else if (!stall) begin
			pc <= pcPlus4;
		end
	end

	// fetch/decode register
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			fetched <= '0;
		end else if (!stall) begin
			if (redirect.valid) begin
				// squash the word fetched behind a taken branch or jump
				fetched <= '0;
			end else begin
				fetched <= '{pcPlus4: pcPlus4, instr: instr};
			end
		end
	end

endmodule

//--- source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic reset,
	input cpuPkg::fetchWord_t fetched,
	input cpuPkg::commit_t commit,
	output logic stall,
	output cpuPkg::redirect_t redirect,
	output cpuPkg::decodeOut_t decoded
);
	import cpuPkg::*;

	word_t instr;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	word_t rsVal;
	word_t rtVal;
	word_t imm;
	ctrl_t ctrl;
	aluOp_t aluOp;
	logic isBeq;
	logic isJump;
	logic isJr;
	regAddr_t dest;
	decodeOut_t nextDecoded;

	assign instr = fetched.instr;
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign imm = {{16{instr[15]}}, instr[15:0]};

	registerFile i_registerFile (
		.clk(clk),
		.reset(reset),
		.rs(rs),
		.rt(rt),
		.commit(commit),
		.rsVal(rsVal),
		.rtVal(rtVal)
	);

	//////////////////////////////
	// control decode
	//////////////////////////////
	always_comb begin
		ctrl = '0;
		aluOp = aluAdd;
		isBeq = 1'b0;
		isJump = 1'b0;
		isJr = 1'b0;
		case (opcode_t'(instr[31:26]))
			rType: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = destRd;
				case (funct_t'(instr[5:0]))
					fnAdd: aluOp = aluAdd;
					fnSub: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnSlt: aluOp = aluSlt;
					// unsupported function codes write nothing
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			addi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			lw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.wbSel = wbMem;
			end
			sw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			beq: isBeq = 1'b1;
			j: isJump = 1'b1;
			jal: begin
				isJump = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = wbLink;
				ctrl.destSel = destLink;
			end
			jr: isJr = 1'b1;
			default: ctrl = '0;
		endcase
	end

	always_comb begin
		case (ctrl.destSel)
			destRd: dest = rd;
			destLink: dest = regAddr_t'(linkReg);
			default: dest = rt;
		endcase
	end

	// load in execute feeding this instruction
	assign stall = decoded.ctrl.memRead && (decoded.rt == rs || decoded.rt == rt);

	//////////////////////////////
	// branch and jump resolution
	//////////////////////////////
	always_comb begin
		redirect.valid = 1'b0;
		redirect.target = fetched.pcPlus4 + {imm[29:0], 2'b00};
		if (isBeq && rsVal == rtVal) begin
			redirect.valid = 1'b1;
		end else if (isJump) begin
			redirect.valid = 1'b1;
			redirect.target = {fetched.pcPlus4[31:28], instr[25:0], 2'b00};
		end else if (isJr) begin
			redirect.valid = 1'b1;
			redirect.target = rsVal;
		end
		// held instruction resolves again once the stall clears
		if (stall) begin
			redirect.valid = 1'b0;
		end
	end

	assign nextDecoded = '{ctrl: ctrl, aluOp: aluOp, rsVal: rsVal, rtVal: rtVal, imm: imm,
		pcPlus4: fetched.pcPlus4, rs: rs, rt: rt, dest: dest};

	// decode/execute register, bubble on a stall
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			decoded <= '0;
		end else if (stall) begin
			decoded <= '0;
		end else begin
			decoded <= nextDecoded;
		end
	end

endmodule

//--- source/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic reset,
	input cpuPkg::decodeOut_t decoded,
	input cpuPkg::commit_t commit,
	output cpuPkg::execOut_t executed
);
	import cpuPkg::*;

	logic memFwdValid;
	word_t memFwdData;
	word_t opA;
	word_t bVal;
	word_t opB;
	word_t aluResult;

	// newest value first: memory stage, then writeback
	function automatic word_t pickOperand(
		input regAddr_t src,
		input word_t regVal,
		input logic memValid,
		input regAddr_t memDest,
		input word_t memData,
		input commit_t wb
	);
		word_t value;
		value = regVal;
		if (src != '0) begin
			if (memValid && memDest == src) begin
				value = memData;
			end else if (wb.valid && wb.dest == src) begin
				value = wb.data;
			end
		end
		return value;
	endfunction

	//////////////////////////////
	// forwarding
	//////////////////////////////
	assign memFwdValid = executed.ctrl.regWrite && executed.dest != '0;
	// jal carries its link value in pcPlus4
	assign memFwdData = (executed.ctrl.wbSel == wbLink) ? executed.pcPlus4 : executed.result;

	assign opA = pickOperand(decoded.rs, decoded.rsVal, memFwdValid, executed.dest,
		memFwdData, commit);
	assign bVal = pickOperand(decoded.rt, decoded.rtVal, memFwdValid, executed.dest,
		memFwdData, commit);
	assign opB = decoded.ctrl.aluSrc ? decoded.imm : bVal;

	//////////////////////////////
	// ALU
	//////////////////////////////
	always_comb begin
		case (decoded.aluOp)
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluSlt: aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
			default: aluResult = opA;
		endcase
	end

	// execute/memory register
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			executed <= '0;
		end else begin
			executed.ctrl <= decoded.ctrl;
			executed.result <= aluResult;
			executed.storeData <= bVal;
			executed.pcPlus4 <= decoded.pcPlus4;
			executed.dest <= decoded.dest;
		end
	end

endmodule

//--- source/memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
	input logic clk,
	input logic reset,
	input cpuPkg::execOut_t executed,
	output cpuPkg::commit_t commit
);
	import cpuPkg::*;

	typedef struct packed {
		ctrl_t ctrl;
		word_t result;
		word_t loadWord;
		word_t pcPlus4;
		regAddr_t dest;
	} memWb_t;

	word_t dataMem [dataWords];
	logic [$clog2(dataWords)-1:0] wordAddr;
	word_t loadWord;
	memWb_t memWb;

	// word index from byte address bits 7:2
	assign wordAddr = executed.result[7:2];
	assign loadWord = dataMem[wordAddr];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < dataWords; i++) begin
				dataMem[i] <= '0;
			end
		end else if (executed.ctrl.memWrite) begin
			dataMem[wordAddr] <= executed.storeData;
		end
	end

	// memory/writeback register
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			memWb <= '0;
		end else begin
			memWb <= '{ctrl: executed.ctrl, result: executed.result, loadWord: loadWord,
				pcPlus4: executed.pcPlus4, dest: executed.dest};
		end
	end

	//////////////////////////////
	// writeback selection
	//////////////////////////////
	assign commit.valid = memWb.ctrl.regWrite && memWb.dest != '0;
	assign commit.dest = memWb.dest;

	always_comb begin
		case (memWb.ctrl.wbSel)
			wbMem: commit.data = memWb.loadWord;
			wbLink: commit.data = memWb.pcPlus4;
			default: commit.data = memWb.result;
		endcase
	end

endmodule

//--- source/pipelineCore.sv
`timescale 1ns/1ps

module pipelineCore (
	input logic clk,
	input logic reset,
	input cpuPkg::word_t instr,
	output cpuPkg::word_t instrAddr,
	output cpuPkg::commit_t commit
);
	import cpuPkg::*;

	logic stall;
	redirect_t redirect;
	fetchWord_t fetched;
	decodeOut_t decoded;
	execOut_t executed;

	fetchStage i_fetchStage (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.instr(instr),
		.instrAddr(instrAddr),
		.fetched(fetched)
	);

	// decode also owns the register file write port
	decodeStage i_decodeStage (
		.clk(clk),
		.reset(reset),
		.fetched(fetched),
		.commit(commit),
		.stall(stall),
		.redirect(redirect),
		.decoded(decoded)
	);

	executeStage i_executeStage (
		.clk(clk),
		.reset(reset),
		.decoded(decoded),
		.commit(commit),
		.executed(executed)
	);

	memoryStage i_memoryStage (
		.clk(clk),
		.reset(reset),
		.executed(executed),
		.commit(commit)
	);

endmodule

//--- sim/coreAsserts.sv
`timescale 1ns/1ps

module coreAsserts (
	input logic clk,
	input logic reset,
	input cpuPkg::word_t instrAddr,
	input cpuPkg::commit_t commit
);
	import cpuPkg::*;

	// register 0 is never written
	property noZeroDest;
		@(posedge clk) disable iff (!reset) commit.valid |-> commit.dest != '0;
	endproperty

	property alignedFetch;
		@(posedge clk) instrAddr[1:0] == 2'b00;
	endproperty

	property quietInReset;
		@(posedge clk) !reset |-> !commit.valid;
	endproperty

	assert property (noZeroDest) else $error("commit to register 0");
	assert property (alignedFetch) else $error("instrAddr not word aligned");
	assert property (quietInReset) else $error("commit.valid high during reset");

endmodule

bind pipelineCore coreAsserts i_coreAsserts (
	.clk(clk),
	.reset(reset),
	.instrAddr(instrAddr),
	.commit(commit)
);

//--- sim/coreChecker.sv
`timescale 1ns/1ps

module coreChecker (
	input logic clk,
	input logic reset,
	input cpuPkg::commit_t commit,
	output int errorCount,
	output int checkCount
);
	import cpuPkg::*;

	regAddr_t expDest[$];
	word_t expData[$];

	initial begin
		errorCount = 0;
		checkCount = 0;
	end

	task automatic clearExpected();
		expDest.delete();
		expData.delete();
	endtask

	task automatic pushExpected(input regAddr_t dest, input word_t data);
		expDest.push_back(dest);
		expData.push_back(data);
	endtask

	// anything still queued never committed
	task automatic finishTest(input int testNum);
		if (expDest.size() != 0) begin
			$display("Test %0d ended with %0d expected commits that never happened",
				testNum, expDest.size());
			errorCount = errorCount + expDest.size();
		end
		clearExpected();
	endtask

	//////////////////////////////
	// commit compare
	//////////////////////////////
	// sampled on the falling edge, where commit is settled
	always @(negedge clk) begin
		regAddr_t wantDest;
		word_t wantData;
		if (reset && commit.valid) begin
			if (expDest.size() == 0) begin
				$display("Unexpected extra commit at %0t to register %0d with data %h",
					$time, commit.dest, commit.data);
				errorCount = errorCount + 1;
			end else begin
				wantDest = expDest.pop_front();
				wantData = expData.pop_front();
				checkCount = checkCount + 1;
				if (commit.dest != wantDest) begin
					$display("FAIL %0t commit.dest expected %0d got %0d",
						$time, wantDest, commit.dest);
					errorCount = errorCount + 1;
				end
				if (commit.data != wantData) begin
					$display("FAIL %0t commit.data expected %h got %h",
						$time, wantData, commit.data);
					errorCount = errorCount + 1;
				end
			end
		end
	end

endmodule

//--- sim/coreTb.sv
`timescale 1ns/1ps

module coreTb;
	import cpuPkg::*;

	logic clk;
	logic reset;
	word_t instr;
	word_t instrAddr;
	commit_t commit;
	int errorCount;
	int checkCount;

	// everything from the tests file, flattened
	word_t progMem [0:1023];
	regAddr_t expDest [0:1023];
	word_t expData [0:1023];
	int progStart [0:63];
	int progLen [0:63];
	int expStart [0:63];
	int expLen [0:63];
	int numTests;
	int numWords;
	int numExp;
	int curBase;
	int curLen;
	int limitCycles;
	logic testsLoaded;

	pipelineCore i_pipelineCore (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrAddr(instrAddr),
		.commit(commit)
	);

	coreChecker i_coreChecker (
		.clk(clk),
		.reset(reset),
		.commit(commit),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// nop past the end of the program
	always @* begin
		if ((instrAddr >> 2) < curLen) instr = progMem[curBase + int'(instrAddr >> 2)];
		else instr = '0;
	end

	//////////////////////////////
	// tests file reader
	//////////////////////////////
	task automatic readTests(output logic fileOk);
		int fd;
		int code;
		int dest;
		word_t value;
		string line;
		fd = $fopen("sim/tests.txt", "r");
		fileOk = (fd != 0);
		if (fileOk) begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 0) begin
					if (line[0] == "T") begin
						progStart[numTests] = numWords;
						progLen[numTests] = 0;
						expStart[numTests] = numExp;
						expLen[numTests] = 0;
						numTests++;
					end else if (line[0] == "P" && numTests > 0) begin
						code = $sscanf(line, "P %h", value);
						progMem[numWords] = value;
						numWords++;
						progLen[numTests-1]++;
					end else if (line[0] == "E" && numTests > 0) begin
						code = $sscanf(line, "E %d %h", dest, value);
						expDest[numExp] = regAddr_t'(dest);
						expData[numExp] = value;
						numExp++;
						expLen[numTests-1]++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic runTest(input int t);
		@(posedge clk);
		#1 reset = 1'b0;
		curBase = progStart[t];
		curLen = progLen[t];
		i_coreChecker.clearExpected();
		for (int k = 0; k < expLen[t]; k++) begin
			i_coreChecker.pushExpected(expDest[expStart[t]+k], expData[expStart[t]+k]);
		end
		repeat (4) @(posedge clk);
		#1 reset = 1'b1;
		// drained once the fetch is well past the last word
		do begin
			@(negedge clk);
		end while (instrAddr < word_t'(curLen * 4 + 24));
		i_coreChecker.finishTest(t);
	endtask

	initial begin
		reset = 1'b0;
		numTests = 0;
		numWords = 0;
		numExp = 0;
		curBase = 0;
		curLen = 0;
		limitCycles = 0;
		readTests(testsLoaded);
		if (!testsLoaded) begin
			$display("Could not open sim/tests.txt");
			$display("Testbench failed");
		end else begin
			limitCycles = 20 * numWords + 20 * numTests;
			for (int t = 0; t < numTests; t++) begin
				runTest(t);
			end
			$display("errors: %0d, commits checked: %0d, tests: %0d",
				errorCount, checkCount, numTests);
			if (errorCount == 0) begin
				$display("Testbench passed");
			end else begin
				$display("Testbench failed");
			end
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge clk);
		$display("Run stopped after %0d cycles without finishing the tests", limitCycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- list.f
source/cpuPkg.sv
source/registerFile.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/pipelineCore.sv
sim/coreAsserts.sv
sim/coreChecker.sv
sim/coreTb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module coreTb -o coreSim

out=$(./obj_dir/coreSim)
echo "$out"

echo "$out" | grep -q "Testbench passed"

//--- sim/tests.txt
# T starts a test, P <instr hex> is a program word in order,
# E <dest reg decimal> <data hex> is an expected commit in order
T alu
P 20010005
P 2002fffd
P 00221820
P 00222022
P 00222824
P 00223025
P 0041382a
P 0022402a
E 1 00000005
E 2 fffffffd
E 3 00000002
E 4 00000008
E 5 00000005
E 6 fffffffd
E 7 00000001
E 8 00000000
T forward
P 20010007
P 00211020
P 00411820
P 00622022
E 1 00000007
E 2 0000000e
E 3 00000015
E 4 00000007
T memory
P 20010055
P ac010008
P 8c020008
P 00421820
E 1 00000055
E 2 00000055
E 3 000000aa
T branch
P 20010001
P 20020001
P 20030002
P 00000000
P 10220001
P 20040009
P 20050006
P 10230001
P 20060007
E 1 00000001
E 2 00000001
E 3 00000002
E 5 00000006
E 6 00000007
T jump
P 0c000004
P 20010001
P 08000007
P 20020002
P 20030003
P 00000000
P 1fe00000
P 20040004
E 31 00000004
E 3 00000003
E 1 00000001
E 4 00000004
